/* vlog.f */
rtl/modred_pkg.sv
rtl/modulus_classifier.sv
rtl/lane_arbiter.sv
rtl/operand_multiplier.sv
rtl/fold_reducer.sv
rtl/result_router.sv
rtl/modred_top.sv
test/modred_tb.sv

/* run.sh */
#!/bin/sh
# build and run the modred testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module modred_tb \
  -f vlog.f \
  -o modred_sim

# exit status is the simulator's, nonzero on $fatal
./obj_dir/modred_sim

/* test/modred_tb.sv */
`timescale 1ns/1ps

module modred_tb import modred_pkg::*; ();

  localparam int unsigned NUM_CHUNKS = 3;
  // sampling edge of a grant to sampling edge of its response
  localparam int unsigned LATENCY = NUM_CHUNKS + 4;
  localparam int unsigned TIMEOUT = 5000;

  logic                 clk;
  logic                 rst_n;
  logic [DATA_W-1:0]    mod;
  logic [BL_W-1:0]      mod_bl;
  logic [NUM_LANES-1:0] req;
  logic [DATA_W-1:0]    op_a [NUM_LANES];
  logic [DATA_W-1:0]    op_b [NUM_LANES];
  logic [NUM_LANES-1:0] grant;
  logic [NUM_LANES-1:0] rsp_valid;
  logic [DATA_W-1:0]    rsp_result [NUM_LANES];
  logic                 cfg_err;

  // stimulus control
  integer               seed;
  logic [DATA_W-1:0]    m_val;
  logic                 mod_bad;
  logic                 lanes_on;

  // reference model, one queue of expected results per lane
  logic [DATA_W-1:0]    exp_q [NUM_LANES][$];
  int unsigned          cyc_q [NUM_LANES][$];
  logic [DATA_W-1:0]    exp_head [NUM_LANES];
  int unsigned          cyc_head [NUM_LANES];
  int unsigned          exp_depth [NUM_LANES];
  int unsigned          wait_cnt [NUM_LANES];
  int unsigned          cyc;
  int unsigned          grants_total;
  int unsigned          outstanding;
  int unsigned          last_lane;
  logic [NUM_LANES-1:0] rr_expect;
  logic                 err_exp;

  modred_top #(
    .NUM_CHUNKS (NUM_CHUNKS)
  ) DUT (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .mod_i        (mod),
    .mod_bl_i     (mod_bl),
    .req_i        (req),
    .operand_a_i  (op_a),
    .operand_b_i  (op_b),
    .grant_o      (grant),
    .rsp_valid_o  (rsp_valid),
    .rsp_result_o (rsp_result),
    .cfg_err_o    (cfg_err)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic mismatch_stop(input string what, input logic [63:0] got,
                               input logic [63:0] want);
    $display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, want);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic abort_run(input string msg);
    $display("error at %0t: %s", $time, msg);
    $display("Errors found");
    $fatal(1);
  endtask

  // operand below m, now and then the largest one
  function automatic logic [DATA_W-1:0] draw_operand();
    logic [31:0] r;
    r = $random(seed);
    if (r[2:0] == 3'd0) begin
      return m_val - 64'd1;
    end
    return {32'd0, r} % m_val;
  endfunction

  // ==================================================
  // lane stimulus
  // ==================================================
  // idle or just granted lanes draw a new pair, waiting lanes hold
  always @(posedge clk) begin
    for (int unsigned l = 0; l < NUM_LANES; l++) begin
      if (!lanes_on) begin
        req[l] <= 1'b0;
      end else if (grant[l] || !req[l]) begin
        op_a[l] <= draw_operand();
        op_b[l] <= draw_operand();
        // mostly high, so both lanes often compete
        req[l]  <= ($random(seed) & 3) != 0;
      end
    end
  end

  // ==================================================
  // reference model
  // ==================================================
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cyc          = 0;
      grants_total = 0;
      outstanding  = 0;
      // lane 0 wins first after reset
      last_lane    = NUM_LANES - 1;
      rr_expect    = NUM_LANES'(1);
      err_exp      = 1'b0;
      for (int unsigned l = 0; l < NUM_LANES; l++) begin
        exp_q[l].delete();
        cyc_q[l].delete();
        exp_head[l]  = '0;
        cyc_head[l]  = 0;
        exp_depth[l] = 0;
        wait_cnt[l]  = 0;
      end
    end else begin
      for (int unsigned l = 0; l < NUM_LANES; l++) begin
        // response taken this edge, drop it first
        if (rsp_valid[l] && exp_q[l].size() != 0) begin
          void'(exp_q[l].pop_front());
          void'(cyc_q[l].pop_front());
          outstanding--;
        end
        if (grant[l]) begin
          exp_q[l].push_back((op_a[l] * op_b[l]) % m_val);
          cyc_q[l].push_back(cyc);
          last_lane = l;
          grants_total++;
          outstanding++;
        end
        wait_cnt[l]  = (req[l] && !grant[l]) ? wait_cnt[l] + 1 : 0;
        exp_depth[l] = exp_q[l].size();
        exp_head[l]  = (exp_q[l].size() != 0) ? exp_q[l][0] : '0;
        cyc_head[l]  = (cyc_q[l].size() != 0) ? cyc_q[l][0] : 0;
      end
      rr_expect = NUM_LANES'(1) << ((last_lane + 1) % NUM_LANES);
      // classifier flag follows the port one edge later
      err_exp   = mod_bad;
      cyc++;
    end
  end

  // ==================================================
  // checks, sampled mid-cycle on stable values
  // ==================================================
  a_reset_quiet: assert property (
    @(negedge clk) !rst_n |-> (grant == '0 && rsp_valid == '0)
  ) else abort_run("grant or response valid raised during reset");

  // both lanes up, winner must be the lane after the last one
  a_alternate: assert property (
    @(negedge clk) disable iff (!rst_n) (&req) |-> grant == rr_expect
  ) else mismatch_stop("grant", 64'(grant), 64'(rr_expect));

  a_cfg_err: assert property (
    @(negedge clk) disable iff (!rst_n) cfg_err == err_exp
  ) else mismatch_stop("cfg_err", 64'(cfg_err), 64'(err_exp));

  for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane_check
    a_owned: assert property (
      @(negedge clk) disable iff (!rst_n) rsp_valid[l] |-> exp_depth[l] != 0
    ) else abort_run("response on a lane with nothing outstanding");

    // in order, on the issuing lane
    a_result: assert property (
      @(negedge clk) disable iff (!rst_n) rsp_valid[l] |-> rsp_result[l] == exp_head[l]
    ) else mismatch_stop("result", rsp_result[l], exp_head[l]);

    a_latency: assert property (
      @(negedge clk) disable iff (!rst_n) rsp_valid[l] |-> (cyc - cyc_head[l]) == LATENCY
    ) else mismatch_stop("latency", 64'(cyc - cyc_head[l]), 64'(LATENCY));

    a_wait: assert property (
      @(negedge clk) disable iff (!rst_n) wait_cnt[l] < NUM_LANES
    ) else abort_run("lane kept waiting for a grant too long");
  end

  task automatic set_modulus(input logic [DATA_W-1:0] m, input logic [BL_W-1:0] bl,
                             input logic bad);
    @(posedge clk);
    mod     <= m;
    mod_bl  <= bl;
    m_val   <= m;
    mod_bad <= bad;
    // one edge into the classifier, one spare
    repeat (2) @(posedge clk);
  endtask

  task automatic run_traffic(input int unsigned n);
    int unsigned start;
    int unsigned t;
    start    = grants_total;
    t        = 0;
    lanes_on <= 1'b1;
    while ((grants_total - start) < n && t < TIMEOUT) begin
      @(posedge clk);
      t++;
    end
    if ((grants_total - start) < n) begin
      abort_run("timeout waiting for grants");
    end else begin
      lanes_on <= 1'b0;
    end
  endtask

  task automatic drain_pipeline();
    int unsigned t;
    t = 0;
    while ((req != '0 || outstanding != 0) && t < TIMEOUT) begin
      @(posedge clk);
      t++;
    end
    if (req != '0 || outstanding != 0) begin
      abort_run("timeout waiting for the pipeline to drain");
    end
  endtask

  initial begin
    seed     = 14;
    rst_n    = 1'b0;
    mod      = 64'h7fff_ffff;
    mod_bl   = 7'd31;
    m_val    = 64'h7fff_ffff;
    mod_bad  = 1'b0;
    lanes_on = 1'b0;
    req      = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      op_a[l] = '0;
      op_b[l] = '0;
    end
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    // mersenne 2^31 - 1
    run_traffic(400);
    drain_pipeline();
    // fermat 2^16 + 1, middle chunk often drives the fold negative
    set_modulus(64'h1_0001, 7'd17, 1'b0);
    run_traffic(400);
    drain_pipeline();
    // unsupported modulus, flag only
    set_modulus(64'd1000, 7'd10, 1'b1);
    // back to mersenne, flag clears and results are good again
    set_modulus(64'h7fff_ffff, 7'd31, 1'b0);
    run_traffic(50);
    drain_pipeline();

    $display("No errors");
    $finish;
  end

endmodule

/* rtl/modred_top.sv */
`timescale 1ns/1ps

module modred_top import modred_pkg::*; #(
  parameter int unsigned NUM_CHUNKS = 3
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // static modulus config
  input  logic [DATA_W-1:0]    mod_i,
  input  logic [BL_W-1:0]      mod_bl_i,
  // lane requests, held until granted
  input  logic [NUM_LANES-1:0] req_i,
  input  logic [DATA_W-1:0]    operand_a_i [NUM_LANES],
  input  logic [DATA_W-1:0]    operand_b_i [NUM_LANES],
  output logic [NUM_LANES-1:0] grant_o,
  // lane responses
  output logic [NUM_LANES-1:0] rsp_valid_o,
  output logic [DATA_W-1:0]    rsp_result_o [NUM_LANES],
  output logic                 cfg_err_o
);

  mod_cfg_t cfg;
  mul_req_t lane_req [NUM_LANES];
  logic     issue_valid;
  mul_req_t issue;
  logic     mul_valid;
  red_req_t mul_out;
  logic     red_valid;
  red_rsp_t red_out;

  // tag each operand pair with its lane
  for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
    assign lane_req[l].operand_a = operand_a_i[l];
    assign lane_req[l].operand_b = operand_b_i[l];
    assign lane_req[l].lane      = lane_id_t'(l);
  end

  // ==================================================
  // config and issue
  // ==================================================
  modulus_classifier u_classifier (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .mod_i     (mod_i),
    .mod_bl_i  (mod_bl_i),
    .cfg_o     (cfg),
    .cfg_err_o (cfg_err_o)
  );

  lane_arbiter #(
    .NUM_LANES (NUM_LANES),
    .payload_t (mul_req_t)
  ) u_arbiter (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (req_i),
    .payload_i (lane_req),
    .grant_o   (grant_o),
    .valid_o   (issue_valid),
    .payload_o (issue)
  );

  // ==================================================
  // shared multiply and fold pipeline
  // ==================================================
  operand_multiplier u_multiplier (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (issue_valid),
    .req_i   (issue),
    .valid_o (mul_valid),
    .req_o   (mul_out)
  );

  fold_reducer #(
    .NUM_CHUNKS (NUM_CHUNKS)
  ) u_reducer (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .cfg_i   (cfg),
    .valid_i (mul_valid),
    .req_i   (mul_out),
    .valid_o (red_valid),
    .rsp_o   (red_out)
  );

  result_router u_router (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .valid_i      (red_valid),
    .rsp_i        (red_out),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_result_o (rsp_result_o)
  );

endmodule

/* rtl/result_router.sv */
`timescale 1ns/1ps

module result_router import modred_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 valid_i,
  input  red_rsp_t             rsp_i,
  output logic [NUM_LANES-1:0] rsp_valid_o,
  output logic [DATA_W-1:0]    rsp_result_o [NUM_LANES]
);

  // per-lane hit on the incoming tag
  logic [NUM_LANES-1:0] hit;

  for (genvar l = 0; l < NUM_LANES; l++) begin : g_hit
    assign hit[l] = valid_i && (rsp_i.lane == lane_id_t'(l));
  end

  // ==================================================
  // one-cycle pulse to the owning lane
  // ==================================================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_o <= '0;
    end else begin
      rsp_valid_o <= hit;
    end
  end

  // result held until the lane's next one
  for (genvar l = 0; l < NUM_LANES; l++) begin : g_hold
    always_ff @(posedge clk_i) begin
      if (hit[l]) begin
        rsp_result_o[l] <= rsp_i.result;
      end
    end
  end

  // single issue stream, never two lanes at once
  a_one_lane: assert property (
    @(posedge clk_i) disable iff (!rst_ni) $onehot0(rsp_valid_o)
  );

endmodule

/* rtl/fold_reducer.sv */
`timescale 1ns/1ps

module fold_reducer import modred_pkg::*; #(
  parameter int unsigned NUM_CHUNKS = 3
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  mod_cfg_t cfg_i,
  input  logic     valid_i,
  input  red_req_t req_i,
  output logic     valid_o,
  output red_rsp_t rsp_o
);

  // chunk idx of p, k bits wide
  function automatic logic [DATA_W-1:0] chunk_of(
    input logic [DATA_W-1:0] p,
    input int unsigned       idx,
    input logic [BL_W-1:0]   k
  );
    logic [DATA_W-1:0] mask;
    int unsigned       sh;
    mask = (64'd1 << k) - 64'd1;
    sh   = idx * k;
    return (p >> sh) & mask;
  endfunction

  // product copies, stage i-1 feeds the chunk of stage i
  logic [DATA_W-1:0]        prod_q [NUM_CHUNKS-1];
  logic signed [DATA_W-1:0] acc_q  [NUM_CHUNKS];
  lane_id_t                 lane_q [NUM_CHUNKS];
  logic [NUM_CHUNKS-1:0]    valid_q;

  logic signed [DATA_W-1:0] m_s;
  logic signed [DATA_W-1:0] sum;
  logic signed [DATA_W-1:0] corr;

  // ==================================================
  // product delay line
  // ==================================================
  for (genvar i = 0; i < NUM_CHUNKS - 1; i++) begin : g_prod
    if (i == 0) begin : g_head
      always_ff @(posedge clk_i) begin
        prod_q[0] <= req_i.product;
      end
    end else begin : g_tail
      always_ff @(posedge clk_i) begin
        prod_q[i] <= prod_q[i-1];
      end
    end
  end

  // ==================================================
  // fold stages
  // ==================================================
  for (genvar i = 0; i < NUM_CHUNKS; i++) begin : g_stage
    if (i == 0) begin : g_first
      // lowest chunk seeds the accumulator
      always_ff @(posedge clk_i) begin
        acc_q[0]  <= $signed(chunk_of(req_i.product, 0, cfg_i.bitlength));
        lane_q[0] <= req_i.lane;
      end
    end else begin : g_fold
      always_ff @(posedge clk_i) begin
        // 2^k = -1 mod m for fermat, odd chunks flip sign
        if (cfg_i.kind == MOD_FERMAT && (i % 2 == 1)) begin
          acc_q[i] <= acc_q[i-1] - $signed(chunk_of(prod_q[i-1], i, cfg_i.bitlength));
        end else begin
          acc_q[i] <= acc_q[i-1] + $signed(chunk_of(prod_q[i-1], i, cfg_i.bitlength));
        end
        lane_q[i] <= lane_q[i-1];
      end
    end
  end

  // valid marks each item through the stages
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      valid_o <= 1'b0;
    end else begin
      valid_q <= {valid_q[NUM_CHUNKS-2:0], valid_i};
      valid_o <= valid_q[NUM_CHUNKS-1];
    end
  end

  // ==================================================
  // correction into 0 .. m-1
  // ==================================================
  assign m_s = $signed(cfg_i.modulus);
  assign sum = acc_q[NUM_CHUNKS-1];

  always_comb begin
    // fermat folds can go negative
    if (sum < 0) begin
      corr = sum + m_s;
    // mersenne sum reaches 2m at most
    end else if (sum >= (m_s <<< 1)) begin
      corr = sum - (m_s <<< 1);
    end else if (sum >= m_s) begin
      corr = sum - m_s;
    end else begin
      corr = sum;
    end
  end

  always_ff @(posedge clk_i) begin
    rsp_o.result <= corr;
    rsp_o.lane   <= lane_q[NUM_CHUNKS-1];
  end

  // in range whenever config is supported
  a_in_range: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      (valid_o && cfg_i.kind != MOD_NONE) |-> rsp_o.result < cfg_i.modulus
  );

endmodule

/* rtl/operand_multiplier.sv */
`timescale 1ns/1ps

module operand_multiplier import modred_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     valid_i,
  input  mul_req_t req_i,
  output logic     valid_o,
  output red_req_t req_o
);

  // full width so overflow is visible
  logic [2*DATA_W-1:0] full_prod;

  assign full_prod = req_i.operand_a * req_i.operand_b;

  // ==================================================
  // single multiply stage
  // ==================================================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // product and tag, no reset needed
  always_ff @(posedge clk_i) begin
    req_o.product <= full_prod[DATA_W-1:0];
    req_o.lane    <= req_i.lane;
  end

  // operands below m < 2^32, so upper half stays clear
  a_no_overflow: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      valid_i |-> full_prod[2*DATA_W-1:DATA_W] == '0
  );

endmodule

/* rtl/lane_arbiter.sv */
`timescale 1ns/1ps

module lane_arbiter #(
  parameter int unsigned NUM_LANES = 2,
  parameter type         payload_t = logic [7:0]
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic [NUM_LANES-1:0] req_i,
  input  payload_t             payload_i [NUM_LANES],
  output logic [NUM_LANES-1:0] grant_o,
  output logic                 valid_o,
  output payload_t             payload_o
);

  localparam int unsigned LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

  // last winner, search starts one past it
  logic [LANE_W-1:0] last_q;
  logic [LANE_W-1:0] win_idx;
  logic              found;

  // ==================================================
  // round-robin pick, combinational grant
  // ==================================================
  always_comb begin
    int unsigned idx;
    idx     = 0;
    found   = 1'b0;
    win_idx = last_q;
    grant_o = '0;
    for (int unsigned o = 1; o <= NUM_LANES; o++) begin
      idx = (last_q + o) % NUM_LANES;
      if (!found && req_i[idx]) begin
        found   = 1'b1;
        win_idx = LANE_W'(idx);
      end
    end
    if (found) begin
      grant_o[win_idx] = 1'b1;
    end
  end

  // issue valid and pointer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_o <= 1'b0;
      // pointer on the last lane so lane 0 wins first
      last_q  <= LANE_W'(NUM_LANES - 1);
    end else begin
      valid_o <= found;
      if (found) begin
        last_q <= win_idx;
      end
    end
  end

  // payload carries its own lane tag
  always_ff @(posedge clk_i) begin
    if (found) begin
      payload_o <= payload_i[win_idx];
    end
  end

  a_grant_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_ni) $onehot0(grant_o)
  );

  a_grant_has_req: assert property (
    @(posedge clk_i) disable iff (!rst_ni) (grant_o & ~req_i) == '0
  );

endmodule

/* rtl/modulus_classifier.sv */
`timescale 1ns/1ps

module modulus_classifier import modred_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [DATA_W-1:0]   mod_i,
  input  logic [BL_W-1:0]     mod_bl_i,
  output mod_cfg_t            cfg_o,
  output logic                cfg_err_o
);

  logic [DATA_W-1:0] ones_pat;
  logic [DATA_W-1:0] fermat_pat;
  logic              is_mersenne;
  logic              is_fermat;

  // all ones over k bits
  assign ones_pat = (64'd1 << mod_bl_i) - 64'd1;
  // top bit and bit 0 only, inner bits clear
  assign fermat_pat = (64'd1 << (mod_bl_i - 7'd1)) | 64'd1;

  // k limited to 31, fermat fold width is bl-1
  assign is_mersenne = (mod_bl_i >= 7'd2) && (mod_bl_i <= 7'd31) && (mod_i == ones_pat);
  assign is_fermat   = (mod_bl_i >= 7'd3) && (mod_bl_i <= 7'd32) && (mod_i == fermat_pat);

  // one cycle from port change to cfg
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_o.modulus   <= '0;
      cfg_o.bitlength <= '0;
      cfg_o.kind      <= MOD_NONE;
      cfg_err_o       <= 1'b0;
    end else begin
      cfg_o.modulus <= mod_i;
      if (is_mersenne) begin
        cfg_o.bitlength <= mod_bl_i;
        cfg_o.kind      <= MOD_MERSENNE;
        cfg_err_o       <= 1'b0;
      end else if (is_fermat) begin
        // fold on the power of two, m = 2^(bl-1) + 1
        cfg_o.bitlength <= mod_bl_i - 7'd1;
        cfg_o.kind      <= MOD_FERMAT;
        cfg_err_o       <= 1'b0;
      end else begin
        cfg_o.bitlength <= mod_bl_i;
        cfg_o.kind      <= MOD_NONE;
        cfg_err_o       <= 1'b1;
      end
    end
  end

  // static config never asks for more than 32 bits
  a_bitlength_range: assert property (
    @(posedge clk_i) disable iff (!rst_ni) mod_bl_i <= 7'd32
  );

endmodule

/* rtl/modred_pkg.sv */
package modred_pkg;

  // ==================================================
  // datapath and lane sizing
  // ==================================================

  // fixes the width of every struct below
  localparam int unsigned DATA_W = 64;
  localparam int unsigned NUM_LANES = 2;
  // wide enough for the largest bitlength port value
  localparam int unsigned BL_W = 7;

  typedef logic [0:0] lane_id_t;

  // ==================================================
  // modulus configuration
  // ==================================================

  // MOD_NONE marks an unsupported modulus
  typedef enum logic [1:0] {
    MOD_NONE     = 2'd0,
    MOD_MERSENNE = 2'd1,
    MOD_FERMAT   = 2'd2
  } mod_kind_e;

  // bitlength here is the fold width k, not the raw port value
  typedef struct packed {
    logic [DATA_W-1:0] modulus;
    logic [BL_W-1:0]   bitlength;
    mod_kind_e         kind;
  } mod_cfg_t;

  // operand pair as issued by a lane
  typedef struct packed {
    logic [DATA_W-1:0] operand_a;
    logic [DATA_W-1:0] operand_b;
    lane_id_t          lane;
  } mul_req_t;

  // raw product on its way into the fold pipeline
  typedef struct packed {
    logic [DATA_W-1:0] product;
    lane_id_t          lane;
  } red_req_t;

  // reduced value in 0 .. m-1
  typedef struct packed {
    logic [DATA_W-1:0] result;
    lane_id_t          lane;
  } red_rsp_t;

endpackage
